//--- ucode_sequencer_top.f
hdl/ucode_pkg.sv
hdl/ctl_bus_pkg.sv
hdl/ucode_ifs.sv
hdl/upc_sequencer.sv
hdl/ucode_store_slice.sv
hdl/control_decoder.sv
hdl/ucode_sequencer_top.sv
dv/ucode_sequencer_checker.sv
dv/ucode_sequencer_tb.sv

//--- Makefile
# Verilator build and run for the microcode sequencer testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ucode_sequencer_tb
FILELIST  = ucode_sequencer_top.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SIM_FLAGS = +verilator+error+limit+100
PASS_TEXT = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$($(SIM) $(SIM_FLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/ucode_sequencer_tb.sv
// Microcode sequencer testbench
// Fills the store with random microcode, runs a table of bank and
// opcode rows under random ctl_ready stalls and checks every decoded
// word against a model built from the store contents

`default_nettype none

module ucode_sequencer_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int ROWS           = 8;
   localparam int LOAD_CYCLES    = ucode_pkg::STORE_DEPTH + 64;   // Reset, load, drain
   localparam int TIMEOUT_CYCLES = ROWS * 16 * 8 + LOAD_CYCLES;

   typedef struct packed {
      ucode_pkg::bank_t  bank;
      ucode_pkg::upc_t   upc;
      logic              last;
      ucode_pkg::uword_t word;
   } expect_t;

   logic                 clk;
   logic                 reset;
   logic                 instr_valid;
   logic                 instr_ready;
   ucode_pkg::opcode_t   instr_opcode;
   logic                 load_valid;
   logic                 load_ready;
   ucode_pkg::uaddr_t    load_addr;
   ucode_pkg::uword_t    load_data;
   logic                 bank_we;
   ucode_pkg::bank_t     bank_data;
   logic                 ctl_valid;
   logic                 ctl_ready;
   ctl_bus_pkg::rd_sel_t ctl_rd_sel;
   ctl_bus_pkg::wr_sel_t ctl_wr_sel;
   ctl_bus_pkg::opif_t   ctl_opif;
   ctl_bus_pkg::strobe_t ctl_strobe;
   logic                 ctl_end;
   ucode_pkg::upc_t      ctl_upc;
   ucode_pkg::bank_t     ctl_bank;

   ////////////////////////////////////////////////////////////
   // Row table of bank, opcode, stall percent and program length
   ////////////////////////////////////////////////////////////
   int row_bank   [ROWS] = '{0, 1, 2, 3, 0, 1, 3, 2};
   int row_opcode [ROWS] = '{0, 5, 9, 15, 7, 12, 2, 4};
   int row_stall  [ROWS] = '{0, 0, 25, 50, 75, 25, 50, 0};
   int row_len    [ROWS] = '{4, 16, 1, 7, 16, 3, 10, 5};   // 16 has no end bit

   ucode_pkg::uword_t store_model [ucode_pkg::STORE_DEPTH];
   expect_t           expect_q [$];        // Words still owed by the DUT
   int                seed;
   int                stall_pct;
   int                cycles;
   int                value_errors;
   int                other_errors;
   int                words_checked;

   ucode_sequencer_top ucode_sequencer_top_inst (
      .clk          (clk),
      .reset        (reset),
      .instr_valid  (instr_valid),
      .instr_ready  (instr_ready),
      .instr_opcode (instr_opcode),
      .load_valid   (load_valid),
      .load_ready   (load_ready),
      .load_addr    (load_addr),
      .load_data    (load_data),
      .bank_we      (bank_we),
      .bank_data    (bank_data),
      .ctl_valid    (ctl_valid),
      .ctl_ready    (ctl_ready),
      .ctl_rd_sel   (ctl_rd_sel),
      .ctl_wr_sel   (ctl_wr_sel),
      .ctl_opif     (ctl_opif),
      .ctl_strobe   (ctl_strobe),
      .ctl_end      (ctl_end),
      .ctl_upc      (ctl_upc),
      .ctl_bank     (ctl_bank)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;               // 20 ns period
   end

   task automatic next_cycle();
      @(posedge clk);
      #2;                                   // Drive point after the edge
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      value_errors++;
      $display("Error: %s got %h expected %h", name, got, exp);
   endtask

   // Random words with the end bit only on the last word of each program
   task automatic build_store();
      int len;
      int a;
      for (int b = 0; b < 4; b++) begin
         for (int op = 0; op < 16; op++) begin
            len = {$random(seed)} % 16 + 1;
            for (int r = 0; r < ROWS; r++) begin
               if (row_bank[r] == b && row_opcode[r] == op) begin
                  len = row_len[r];
               end
            end
            for (int u = 0; u < 16; u++) begin
               a = b * 256 + op * 16 + u;      // {bank, opcode, upc}
               store_model[a] = ucode_pkg::uword_t'($random(seed));
               store_model[a][ucode_pkg::END_BIT] = (u == len - 1) && (len < 16);
            end
         end
      end
   endtask

   task automatic load_store();
      for (int a = 0; a < ucode_pkg::STORE_DEPTH; a++) begin
         load_valid = 1'b1;
         load_addr  = ucode_pkg::uaddr_t'(a);
         load_data  = store_model[a];
         while (!load_ready) begin
            next_cycle();
         end
         next_cycle();                      // One word per transfer
      end
      load_valid = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // Predict, issue and time one instruction
   ////////////////////////////////////////////////////////////
   task automatic run_program(input int r);
      int      len;
      int      low_cycles;
      expect_t e;
      len = 0;
      do begin
         e.bank = ucode_pkg::bank_t'(row_bank[r]);
         e.upc  = ucode_pkg::upc_t'(len);
         e.word = store_model[row_bank[r] * 256 + row_opcode[r] * 16 + len];
         e.last = e.word[ucode_pkg::END_BIT] || (len == 15);   // Forced stop at 15
         expect_q.push_back(e);
         len++;
      end while (!e.last);
      stall_pct    = row_stall[r];
      instr_valid  = 1'b1;
      instr_opcode = ucode_pkg::opcode_t'(row_opcode[r]);
      while (!instr_ready) begin
         next_cycle();
      end
      next_cycle();                         // Accepted on this edge
      instr_valid = 1'b0;
      bank_we     = 1'b1;                   // Next row's bank while this one runs
      bank_data   = ucode_pkg::bank_t'(row_bank[(r + 1) % ROWS]);
      low_cycles  = 0;
      while (!instr_ready) begin
         low_cycles++;
         next_cycle();
         bank_we = 1'b0;
      end
      bank_we = 1'b0;
      // Two cycles per word at best, exactly two with no stalls
      if (low_cycles < 2 * len || (row_stall[r] == 0 && low_cycles != 2 * len)) begin
         other_errors++;
         $display("Row %0d: instr_ready low for %0d cycles, %0d words need %0d",
                  r, low_cycles, len, 2 * len);
      end
   endtask

   task automatic check_word(input expect_t e);
      logic [ucode_pkg::RUNIT_WIDTH-1:0] runit;
      logic [ucode_pkg::WUNIT_WIDTH-1:0] wunit;
      ctl_bus_pkg::rd_sel_t              exp_rd;
      ctl_bus_pkg::wr_sel_t              exp_wr;
      runit  = e.word[ucode_pkg::RUNIT_LSB +: ucode_pkg::RUNIT_WIDTH];
      wunit  = e.word[ucode_pkg::WUNIT_LSB +: ucode_pkg::WUNIT_WIDTH];
      exp_rd = (runit == 0) ? '0 : (ctl_bus_pkg::rd_sel_t'(1) << runit);   // Unit 0 idle
      exp_wr = (wunit == 0) ? '0 : (ctl_bus_pkg::wr_sel_t'(1) << wunit);
      words_checked++;
      if (ctl_upc !== e.upc) begin
         report_mismatch("ctl_upc", 32'(ctl_upc), 32'(e.upc));
      end
      if (ctl_bank !== e.bank) begin
         report_mismatch("ctl_bank", 32'(ctl_bank), 32'(e.bank));
      end
      if (ctl_end !== e.last) begin
         report_mismatch("ctl_end", 32'(ctl_end), 32'(e.last));
      end
      if (ctl_rd_sel !== exp_rd) begin
         report_mismatch("ctl_rd_sel", 32'(ctl_rd_sel), 32'(exp_rd));
      end
      if (ctl_wr_sel !== exp_wr) begin
         report_mismatch("ctl_wr_sel", 32'(ctl_wr_sel), 32'(exp_wr));
      end
      if (ctl_opif !== e.word[ucode_pkg::OPIF_LSB +: ucode_pkg::OPIF_WIDTH]) begin
         report_mismatch("ctl_opif", 32'(ctl_opif),
                         32'(e.word[ucode_pkg::OPIF_LSB +: ucode_pkg::OPIF_WIDTH]));
      end
      if (ctl_strobe !== e.word[ucode_pkg::STROBE_LSB +: ucode_pkg::STROBE_WIDTH]) begin
         report_mismatch("ctl_strobe", 32'(ctl_strobe),
                         32'(e.word[ucode_pkg::STROBE_LSB +: ucode_pkg::STROBE_WIDTH]));
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Output side with random stalls one step ahead of the drivers
   ////////////////////////////////////////////////////////////
   initial begin
      forever begin
         @(posedge clk);
         #1;
         if (reset) begin
            ctl_ready = 1'b0;
         end else begin
            ctl_ready = ({$random(seed)} % 100) >= stall_pct;
            if (ctl_valid && ctl_ready) begin   // Transfer on the coming edge
               if (expect_q.size() == 0) begin
                  other_errors++;
                  $display("Extra word delivered at uPC %0d bank %0d", ctl_upc, ctl_bank);
               end else begin
                  check_word(expect_q.pop_front());
               end
            end
         end
      end
   end

   initial begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: run did not finish within %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      seed          = 90170;
      reset         = 1'b1;
      instr_valid   = 1'b0;
      instr_opcode  = '0;
      load_valid    = 1'b0;
      load_addr     = '0;
      load_data     = '0;
      bank_we       = 1'b0;
      bank_data     = '0;
      ctl_ready     = 1'b0;
      stall_pct     = 0;
      value_errors  = 0;
      other_errors  = 0;
      words_checked = 0;
      build_store();
      repeat (16) @(posedge clk);
      #2;
      reset = 1'b0;
      next_cycle();
      if (ctl_valid !== 1'b0) begin
         report_mismatch("ctl_valid", 32'(ctl_valid), 32'h0);
      end
      if (instr_ready !== 1'b1) begin
         report_mismatch("instr_ready", 32'(instr_ready), 32'h1);
      end
      if (load_ready !== 1'b1) begin
         report_mismatch("load_ready", 32'(load_ready), 32'h1);
      end
      load_store();
      bank_we   = 1'b1;                     // Bank for the first row
      bank_data = ucode_pkg::bank_t'(row_bank[0]);
      next_cycle();
      bank_we   = 1'b0;
      for (int r = 0; r < ROWS; r++) begin
         while (expect_q.size() != 0) begin
            next_cycle();
         end
         run_program(r);
      end
      while (expect_q.size() != 0) begin
         next_cycle();
      end
      repeat (8) next_cycle();              // Catch a stray extra word
      other_errors += ucode_sequencer_top_inst.u_dec.u_checker.fail_count;
      $display("Words checked %0d, value errors %0d, other errors %0d",
               words_checked, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- dv/ucode_sequencer_checker.sv
// Control decoder protocol checker
// Bound into the decoder, watches the output handshake, the select
// encoding, the buffer occupancy and the state after reset

`default_nettype none

module ucode_sequencer_checker (
   input logic                 clk,
   input logic                 reset,
   input logic                 ctl_valid,
   input logic                 ctl_ready,
   input ctl_bus_pkg::rd_sel_t ctl_rd_sel,
   input ctl_bus_pkg::wr_sel_t ctl_wr_sel,
   input ctl_bus_pkg::opif_t   ctl_opif,
   input ctl_bus_pkg::strobe_t ctl_strobe,
   input logic                 ctl_end,
   input ucode_pkg::upc_t      ctl_upc,
   input ucode_pkg::bank_t     ctl_bank,
   input logic                 push,
   input logic                 pop,
   input logic [1:0]           count
);

   timeunit 1ns;
   timeprecision 100ps;

   int unsigned            fail_count = 0;   // Failed assertions so far
   ctl_bus_pkg::ctl_word_t held;

   assign held = {ctl_rd_sel, ctl_wr_sel, ctl_opif, ctl_strobe, ctl_end, ctl_upc, ctl_bank};

   ////////////////////////////////////////////////////////////
   // Output port rules
   ////////////////////////////////////////////////////////////
   stall_hold: assert property (@(posedge clk) disable iff (reset)
      ctl_valid && !ctl_ready |=> ctl_valid && $stable(held))
      else begin
         $error("control word changed or dropped while stalled");
         fail_count++;
      end

   rd_onehot: assert property (@(posedge clk) disable iff (reset)
      ctl_valid |-> $onehot0(ctl_rd_sel) && $onehot0(ctl_wr_sel))
      else begin
         $error("unit select has more than one bit set");
         fail_count++;
      end

   // Buffer full and nothing leaving
   no_overflow: assert property (@(posedge clk) disable iff (reset)
      push && !pop |-> count < 2'(ctl_bus_pkg::CTL_FIFO_DEPTH))
      else begin
         $error("word pushed into a full output buffer");
         fail_count++;
      end

   idle_after_reset: assert property (@(posedge clk) reset |=> !ctl_valid)
      else begin
         $error("ctl_valid high in the cycle after reset");
         fail_count++;
      end

endmodule

bind control_decoder ucode_sequencer_checker u_checker (
   .clk        (clk),
   .reset      (reset),
   .ctl_valid  (ctl_valid),
   .ctl_ready  (ctl_ready),
   .ctl_rd_sel (ctl_rd_sel),
   .ctl_wr_sel (ctl_wr_sel),
   .ctl_opif   (ctl_opif),
   .ctl_strobe (ctl_strobe),
   .ctl_end    (ctl_end),
   .ctl_upc    (ctl_upc),
   .ctl_bank   (ctl_bank),
   .push       (push),
   .pop        (pop),
   .count      (count)
);

`default_nettype wire

//--- hdl/ucode_sequencer_top.sv
// Microcode sequencer top level
// uPC sequencer, three byte-wide store slices and the control
// decoder joined by the store access and microword interfaces

`default_nettype none

module ucode_sequencer_top (
   input  logic                 clk,
   input  logic                 reset,
   // Instruction port
   input  logic                 instr_valid,
   output logic                 instr_ready,
   input  ucode_pkg::opcode_t   instr_opcode,
   // Store load port
   input  logic                 load_valid,
   output logic                 load_ready,
   input  ucode_pkg::uaddr_t    load_addr,
   input  ucode_pkg::uword_t    load_data,
   // Bank register
   input  logic                 bank_we,
   input  ucode_pkg::bank_t     bank_data,
   // Decoded control output
   output logic                 ctl_valid,
   input  logic                 ctl_ready,
   output ctl_bus_pkg::rd_sel_t ctl_rd_sel,
   output ctl_bus_pkg::wr_sel_t ctl_wr_sel,
   output ctl_bus_pkg::opif_t   ctl_opif,
   output ctl_bus_pkg::strobe_t ctl_strobe,
   output logic                 ctl_end,
   output ucode_pkg::upc_t      ctl_upc,
   output ucode_pkg::bank_t     ctl_bank
);

   ucode_access_if   acc ();
   ucode_word_if     wrd ();
   ucode_pkg::upc_t  fetch_upc;              // Tags aligned with wrd.word
   ucode_pkg::bank_t fetch_bank;

   ////////////////////////////////////////////////////////////
   // Sequencer
   ////////////////////////////////////////////////////////////
   upc_sequencer u_seq (
      .clk          (clk),
      .reset        (reset),
      .instr_valid  (instr_valid),
      .instr_ready  (instr_ready),
      .instr_opcode (instr_opcode),
      .load_valid   (load_valid),
      .load_ready   (load_ready),
      .load_addr    (load_addr),
      .load_data    (load_data),
      .bank_we      (bank_we),
      .bank_data    (bank_data),
      .acc          (acc),
      .wrd          (wrd),
      .upc          (fetch_upc),
      .bank         (fetch_bank)
   );

   ////////////////////////////////////////////////////////////
   // Store slices, byte i on slice i
   ////////////////////////////////////////////////////////////
   for (genvar i = 0; i < ucode_pkg::SLICE_COUNT; i++) begin : g_slice
      ucode_store_slice u_slice (
         .clk     (clk),
         .acc     (acc),
         .wr_byte (acc.wr_data[i*ucode_pkg::SLICE_WIDTH +: ucode_pkg::SLICE_WIDTH]),
         .rd_byte (wrd.word[i*ucode_pkg::SLICE_WIDTH +: ucode_pkg::SLICE_WIDTH])
      );
   end

   ////////////////////////////////////////////////////////////
   // Decoder
   ////////////////////////////////////////////////////////////
   control_decoder u_dec (
      .clk        (clk),
      .reset      (reset),
      .wrd        (wrd),
      .upc        (fetch_upc),
      .bank       (fetch_bank),
      .ctl_valid  (ctl_valid),
      .ctl_ready  (ctl_ready),
      .ctl_rd_sel (ctl_rd_sel),
      .ctl_wr_sel (ctl_wr_sel),
      .ctl_opif   (ctl_opif),
      .ctl_strobe (ctl_strobe),
      .ctl_end    (ctl_end),
      .ctl_upc    (ctl_upc),
      .ctl_bank   (ctl_bank)
   );

endmodule

`default_nettype wire

//--- hdl/control_decoder.sv
// Microword control decoder
// Turns RUNIT and WUNIT into one-hot selects, passes OPIF and the
// strobes, flags the last word, registers the result and queues it
// in a two-entry buffer in front of the valid/ready control port

`default_nettype none

module control_decoder (
   input  logic                 clk,
   input  logic                 reset,
   ucode_word_if.decoder        wrd,
   input  ucode_pkg::upc_t      upc,
   input  ucode_pkg::bank_t     bank,
   output logic                 ctl_valid,
   input  logic                 ctl_ready,
   output ctl_bus_pkg::rd_sel_t ctl_rd_sel,
   output ctl_bus_pkg::wr_sel_t ctl_wr_sel,
   output ctl_bus_pkg::opif_t   ctl_opif,
   output ctl_bus_pkg::strobe_t ctl_strobe,
   output logic                 ctl_end,
   output ucode_pkg::upc_t      ctl_upc,
   output ucode_pkg::bank_t     ctl_bank
);

   logic [ucode_pkg::RUNIT_WIDTH-1:0] runit;
   logic [ucode_pkg::WUNIT_WIDTH-1:0] wunit;
   ctl_bus_pkg::rd_sel_t   dec_rd_sel;
   ctl_bus_pkg::wr_sel_t   dec_wr_sel;
   logic                   dec_end;
   ctl_bus_pkg::ctl_word_t dec_word;
   logic                   stage_valid;      // Decode register
   ctl_bus_pkg::ctl_word_t stage_word;
   ctl_bus_pkg::ctl_word_t fifo_mem [ctl_bus_pkg::CTL_FIFO_DEPTH];
   logic                   wr_ptr;
   logic                   rd_ptr;
   logic [1:0]             count;            // Buffer occupancy
   logic [2:0]             fill;             // Occupancy plus words in flight
   logic                   push;
   logic                   pop;

   ////////////////////////////////////////////////////////////
   // Field decode
   ////////////////////////////////////////////////////////////
   always_comb begin
      runit      = wrd.word[ucode_pkg::RUNIT_LSB +: ucode_pkg::RUNIT_WIDTH];
      wunit      = wrd.word[ucode_pkg::WUNIT_LSB +: ucode_pkg::WUNIT_WIDTH];
      dec_rd_sel = '0;
      dec_wr_sel = '0;
      if (runit != '0) begin
         dec_rd_sel[runit] = 1'b1;           // Unit 0 is no read
      end
      if (wunit != '0) begin
         dec_wr_sel[wunit] = 1'b1;           // Unit 0 is no write
      end
   end

   assign dec_end  = wrd.word[ucode_pkg::END_BIT] || (upc == ucode_pkg::UPC_LAST);
   assign dec_word = {dec_rd_sel,
                      dec_wr_sel,
                      wrd.word[ucode_pkg::OPIF_LSB +: ucode_pkg::OPIF_WIDTH],
                      wrd.word[ucode_pkg::STROBE_LSB +: ucode_pkg::STROBE_WIDTH],
                      dec_end,
                      upc,
                      bank};

   always_ff @(posedge clk) begin
      if (reset) begin
         stage_valid <= 1'b0;
      end else begin
         stage_valid <= wrd.valid;           // Every valid word is taken
      end
   end

   always_ff @(posedge clk) begin
      if (wrd.valid) begin
         stage_word <= dec_word;
      end
   end

   ////////////////////////////////////////////////////////////
   // Output buffer
   ////////////////////////////////////////////////////////////
   assign push = stage_valid;
   assign pop  = ctl_valid && ctl_ready;

   // Room is counted against words already fetched or decoded
   assign fill      = {1'b0, count} + {2'b00, stage_valid} + {2'b00, wrd.valid};
   assign wrd.ready = (fill < 3'(ctl_bus_pkg::CTL_FIFO_DEPTH));

   always_ff @(posedge clk) begin
      if (push) begin
         fifo_mem[wr_ptr] <= stage_word;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ~wr_ptr;
         end
         if (pop) begin
            rd_ptr <= ~rd_ptr;
         end
         case ({push, pop})
            2'b10:   count <= count + 2'd1;
            2'b01:   count <= count - 2'd1;
            default: count <= count;         // Both or neither
         endcase
      end
   end

   assign ctl_valid = (count != '0);
   assign {ctl_rd_sel, ctl_wr_sel, ctl_opif, ctl_strobe,
           ctl_end, ctl_upc, ctl_bank} = fifo_mem[rd_ptr];   // Head held until popped

endmodule

`default_nettype wire

//--- hdl/ucode_store_slice.sv
// Microcode store slice
// One byte lane of the writable store, 1024 entries deep, with a
// synchronous write and a registered read

`default_nettype none

module ucode_store_slice (
   input  logic              clk,
   ucode_access_if.slave     acc,
   input  ucode_pkg::slice_t wr_byte,
   output ucode_pkg::slice_t rd_byte
);

   ucode_pkg::slice_t mem [ucode_pkg::STORE_DEPTH];   // Byte lane storage

   ////////////////////////////////////////////////////////////
   // Write port
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (acc.wr_en) begin
         mem[acc.addr] <= wr_byte;           // Load port word, this lane
      end
   end

   ////////////////////////////////////////////////////////////
   // Read port
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (acc.rd_en) begin
         rd_byte <= mem[acc.addr];           // Valid the cycle after rd_en
      end
   end

endmodule

`default_nettype wire

//--- hdl/upc_sequencer.sv
// Micro-program counter sequencer
// Accepts an opcode, latches it with the pending bank and steps the
// uPC through the store one read at a time until the end bit or the
// last uPC. While idle it turns load port transfers into store writes

`default_nettype none

module upc_sequencer (
   input  logic                clk,
   input  logic                reset,
   input  logic                instr_valid,
   output logic                instr_ready,
   input  ucode_pkg::opcode_t  instr_opcode,
   input  logic                load_valid,
   output logic                load_ready,
   input  ucode_pkg::uaddr_t   load_addr,
   input  ucode_pkg::uword_t   load_data,
   input  logic                bank_we,
   input  ucode_pkg::bank_t    bank_data,
   ucode_access_if.master      acc,
   ucode_word_if.sequencer     wrd,
   output ucode_pkg::upc_t     upc,
   output ucode_pkg::bank_t    bank
);

   typedef enum logic [1:0] {
      IDLE,                                  // Waiting for opcode or load
      FETCH,                                 // Read pending on ready
      WAIT                                   // Word on its way back
   } state_t;

   state_t             state;
   ucode_pkg::bank_t   pending_bank;         // Written by bank_we
   ucode_pkg::bank_t   active_bank;          // Bank of running program
   ucode_pkg::opcode_t opcode;               // Latched IR[15:12]
   ucode_pkg::upc_t    upc_cnt;
   logic               rd_go;
   logic               word_last;
   logic               accept;

   ////////////////////////////////////////////////////////////
   // Handshakes and store access
   ////////////////////////////////////////////////////////////
   assign instr_ready = (state == IDLE);
   assign load_ready  = (state == IDLE);
   assign accept      = instr_valid && (state == IDLE);

   assign rd_go       = (state == FETCH) && wrd.ready;   // Only with room downstream

   assign acc.rd_en   = rd_go;
   assign acc.wr_en   = load_valid && (state == IDLE);
   assign acc.addr    = (state == IDLE) ? load_addr
                                        : {active_bank, opcode, upc_cnt};
   assign acc.wr_data = load_data;

   // End bit or forced stop at the top of the uPC range
   assign word_last   = wrd.word[ucode_pkg::END_BIT] || (upc_cnt == ucode_pkg::UPC_LAST);

   ////////////////////////////////////////////////////////////
   // FSM, bank registers and uPC
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= IDLE;
         pending_bank <= '0;
         active_bank  <= '0;
         upc_cnt      <= '0;
         wrd.valid    <= 1'b0;
      end else begin
         wrd.valid <= rd_go;                 // Word lands next cycle
         if (bank_we) begin
            pending_bank <= bank_data;       // Used at next acceptance
         end
         case (state)
            IDLE: begin
               if (accept) begin
                  active_bank <= pending_bank;
                  upc_cnt     <= '0;
                  state       <= FETCH;
               end
            end
            FETCH: begin
               if (rd_go) begin
                  state <= WAIT;
               end
            end
            WAIT: begin
               if (word_last) begin
                  state <= IDLE;             // Program done
               end else begin
                  upc_cnt <= upc_cnt + 1'b1;
                  state   <= FETCH;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // Opcode is payload
   always_ff @(posedge clk) begin
      if (accept) begin
         opcode <= instr_opcode;
      end
   end

   ////////////////////////////////////////////////////////////
   // Tags that travel with each fetch
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         upc  <= '0;
         bank <= '0;
      end else if (rd_go) begin
         upc  <= upc_cnt;                    // Aligned with wrd.valid
         bank <= active_bank;
      end
   end

endmodule

`default_nettype wire

//--- hdl/ucode_ifs.sv
// Microcode store interfaces
// ucode_access_if carries reads and writes from the sequencer to
// the store slices, ucode_word_if carries fetched microwords from
// the slices to the control decoder with a ready for buffer space

`default_nettype none

////////////////////////////////////////////////////////////
// Store access
////////////////////////////////////////////////////////////
interface ucode_access_if;

   logic              rd_en;     // Read, data one cycle later
   logic              wr_en;     // Write whole word
   ucode_pkg::uaddr_t addr;
   ucode_pkg::uword_t wr_data;   // Byte i goes to slice i

   modport master (
      output rd_en,
      output wr_en,
      output addr,
      output wr_data
   );

   modport slave (
      input rd_en,
      input wr_en,
      input addr,
      input wr_data
   );

endinterface

////////////////////////////////////////////////////////////
// Fetched microword
////////////////////////////////////////////////////////////
interface ucode_word_if;

   logic                   valid;   // From sequencer
   wire ucode_pkg::uword_t word;    // One byte per slice
   logic                   ready;   // Decoder has room

   modport sequencer (
      output valid,
      input  word,
      input  ready
   );

   modport decoder (
      input  valid,
      input  word,
      output ready
   );

endinterface

`default_nettype wire

//--- hdl/ctl_bus_pkg.sv
// Decoded control bus definitions
// Unit counts and the types of the select, operation and strobe
// fields, plus the packed entry held in the decoder output buffer

`default_nettype none

package ctl_bus_pkg;

   localparam int RD_UNITS = 1 << ucode_pkg::RUNIT_WIDTH;   // 16 read units
   localparam int WR_UNITS = 1 << ucode_pkg::WUNIT_WIDTH;   // 8 write units

   typedef logic [RD_UNITS-1:0]                 rd_sel_t;   // One-hot or zero
   typedef logic [WR_UNITS-1:0]                 wr_sel_t;   // One-hot or zero
   typedef logic [ucode_pkg::OPIF_WIDTH-1:0]    opif_t;
   typedef logic [ucode_pkg::STROBE_WIDTH-1:0]  strobe_t;

   // Buffer entry {rd_sel, wr_sel, opif, strobe, end, upc, bank}
   localparam int CTL_WORD_WIDTH = RD_UNITS + WR_UNITS + ucode_pkg::OPIF_WIDTH
                                 + ucode_pkg::STROBE_WIDTH + 1
                                 + ucode_pkg::UPC_WIDTH + ucode_pkg::BANK_WIDTH;
   localparam int CTL_FIFO_DEPTH = 2;

   typedef logic [CTL_WORD_WIDTH-1:0] ctl_word_t;

endpackage

`default_nettype wire

//--- hdl/ucode_pkg.sv
// Microcode store definitions
// Widths of the uPC, opcode, bank and store address, the field
// map of the 24-bit microword and the geometry of the store slices

`default_nettype none

package ucode_pkg;

   ////////////////////////////////////////////////////////////
   // Address and word geometry
   ////////////////////////////////////////////////////////////
   localparam int UPC_WIDTH    = 4;                     // 16 steps per program
   localparam int OPCODE_WIDTH = 4;                     // IR[15:12]
   localparam int BANK_WIDTH   = 2;                     // UCB bank select
   localparam int UADDR_WIDTH  = BANK_WIDTH + OPCODE_WIDTH + UPC_WIDTH;
   localparam int STORE_DEPTH  = 1 << UADDR_WIDTH;      // 1024 microwords

   localparam int SLICE_COUNT  = 3;                     // Byte-wide memories
   localparam int SLICE_WIDTH  = 8;
   localparam int UWORD_WIDTH  = SLICE_COUNT * SLICE_WIDTH;

   typedef logic [UPC_WIDTH-1:0]    upc_t;
   typedef logic [OPCODE_WIDTH-1:0] opcode_t;
   typedef logic [BANK_WIDTH-1:0]   bank_t;
   typedef logic [UADDR_WIDTH-1:0]  uaddr_t;              // {bank, opcode, upc}
   typedef logic [UWORD_WIDTH-1:0]  uword_t;
   typedef logic [SLICE_WIDTH-1:0]  slice_t;

   localparam upc_t UPC_LAST = upc_t'(15);              // Forced end of program

   ////////////////////////////////////////////////////////////
   // Microword field map
   ////////////////////////////////////////////////////////////
   localparam int RUNIT_LSB    = 0;                     // Read unit number
   localparam int RUNIT_WIDTH  = 4;
   localparam int WUNIT_LSB    = 4;                     // Write unit number
   localparam int WUNIT_WIDTH  = 3;
   localparam int OPIF_LSB     = 7;                     // ALU operation
   localparam int OPIF_WIDTH   = 4;
   // CPL CLL STI CLI INCPC STPDR STPAC DEC MEM IO R WEN from bit 11 up
   localparam int STROBE_LSB   = 11;
   localparam int STROBE_WIDTH = 12;
   localparam int END_BIT      = 23;                    // Last word of program

endpackage

`default_nettype wire
